// ==== hw/cpuIsaPkg.sv ====
// Instruction set definitions for the single-cycle core
// Opcodes, field positions and the decoder output encodings
package cpuIsaPkg;

  // ----------------------------------------
  // Control field types
  // ----------------------------------------
  typedef logic [5:0] opcode_t;
  typedef logic [1:0] regDst_t;   // Write register select
  typedef logic [1:0] memtoReg_t; // Write data select
  typedef logic [1:0] jump_t;     // Next-PC override
  typedef logic [2:0] aluOp_t;

  // ----------------------------------------
  // Opcodes, instruction bits 31 to 26
  // ----------------------------------------
  localparam opcode_t OpAdd  = 6'b100000;
  localparam opcode_t OpSub  = 6'b100010;
  localparam opcode_t OpSlt  = 6'b101010;
  localparam opcode_t OpXori = 6'b001110;
  localparam opcode_t OpAddi = 6'b001000;
  localparam opcode_t OpLw   = 6'b100011;
  localparam opcode_t OpSw   = 6'b101011;
  localparam opcode_t OpBeq  = 6'b000100;
  localparam opcode_t OpJ    = 6'b000010;
  localparam opcode_t OpJal  = 6'b000011;
  localparam opcode_t OpJr   = 6'b001001; // Jump through rs

  // Field positions
  localparam int OpHi     = 31;
  localparam int OpLo     = 26;
  localparam int RsHi     = 25;
  localparam int RsLo     = 21;
  localparam int RtHi     = 20;
  localparam int RtLo     = 16;
  localparam int RdHi     = 15;
  localparam int RdLo     = 11;
  localparam int ImmHi    = 15; // Also the sign bit
  localparam int ImmLo    = 0;
  localparam int TargetHi = 25;
  localparam int TargetLo = 0;

  // ----------------------------------------
  // Decoder output encodings
  // ----------------------------------------
  localparam regDst_t   DstRd    = 2'b00;
  localparam regDst_t   DstRt    = 2'b01;
  localparam regDst_t   DstRa    = 2'b10; // Link register
  localparam memtoReg_t FromAlu  = 2'b00;
  localparam memtoReg_t FromMem  = 2'b01;
  localparam memtoReg_t FromLink = 2'b10; // pc+4 for jal
  localparam jump_t     JumpNone = 2'b00;
  localparam jump_t     JumpAbs  = 2'b01;
  localparam jump_t     JumpReg  = 2'b10;
  localparam aluOp_t    AluNone  = 3'b000;
  localparam aluOp_t    AluAdd   = 3'b001;
  localparam aluOp_t    AluSub   = 3'b010;
  localparam aluOp_t    AluSlt   = 3'b011;
  localparam aluOp_t    AluXor   = 3'b100;

  localparam logic [4:0] LinkReg = 5'd31; // jal target register

endpackage

// ==== hw/cpuCfgPkg.sv ====
// Datapath configuration for the single-cycle core
// Word and register address types, default memory depths
package cpuCfgPkg;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------
  localparam int WordBits = 32;
  localparam int RegCount = 32; // r0 hardwired to zero

  typedef logic [WordBits-1:0] word_t;    // Data, addresses, instructions
  typedef logic [4:0]          regAddr_t; // Register index

  // ----------------------------------------
  // Memory depths in words
  // ----------------------------------------
  localparam int DefaultIMemWords = 256;
  localparam int DefaultDMemWords = 256;

endpackage

// ==== hw/control.sv ====
`timescale 1ns/10ps
// Main decoder for the single-cycle core
// Maps the opcode straight to datapath controls and the ALU operation
module control (
  input  cpuIsaPkg::opcode_t   instruction, // Bits 31 to 26
  output cpuIsaPkg::regDst_t   regDst,
  output logic                 branch,
  output logic                 memRead,
  output cpuIsaPkg::memtoReg_t memtoReg,
  output cpuIsaPkg::aluOp_t    aluOp,
  output logic                 memWrite,
  output logic                 aluSrc,
  output logic                 regWrite,
  output cpuIsaPkg::jump_t     jump
);
  import cpuIsaPkg::*;

  always_comb begin
    // Defaults make any unknown opcode a no-op
    regDst   = DstRd;
    branch   = 1'b0;
    memRead  = 1'b0;
    memtoReg = FromAlu;
    aluOp    = AluNone;
    memWrite = 1'b0;
    aluSrc   = 1'b0;
    regWrite = 1'b0;
    jump     = JumpNone;

    case (instruction)
      // ----------------------------------------
      // Register-register arithmetic
      // ----------------------------------------
      OpAdd: begin
        regWrite = 1'b1;
        aluOp    = AluAdd;
      end
      OpSub: begin
        regWrite = 1'b1;
        aluOp    = AluSub;
      end
      OpSlt: begin
        regWrite = 1'b1;
        aluOp    = AluSlt; // Signed compare
      end

      // Immediate forms write rt
      OpXori: begin
        regDst   = DstRt;
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluOp    = AluXor;
      end
      OpAddi: begin
        regDst   = DstRt;
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluOp    = AluAdd;
      end

      // ----------------------------------------
      // Memory and control flow
      // ----------------------------------------
      OpLw: begin
        regDst   = DstRt;
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        memtoReg = FromMem;
        aluOp    = AluAdd; // Base plus offset
      end
      OpSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluOp    = AluAdd;
      end
      OpBeq: begin
        branch = 1'b1;
        aluOp  = AluSub; // Zero flag means equal
      end
      OpJ:  jump = JumpAbs;
      OpJal: begin
        jump     = JumpAbs;
        regDst   = DstRa;
        memtoReg = FromLink;
        regWrite = 1'b1;
      end
      OpJr: jump = JumpReg;
      default: ; // Keep no-op defaults
    endcase
  end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps
// Arithmetic-logic unit for the single-cycle core
// Add, subtract, signed set-less-than and xor, plus a zero flag
module alu (
  input  cpuIsaPkg::aluOp_t aluOp,
  input  cpuCfgPkg::word_t  a,
  input  cpuCfgPkg::word_t  b,
  output cpuCfgPkg::word_t  result,
  output logic              zero
);
  import cpuIsaPkg::*;
  import cpuCfgPkg::*;

  word_t sum;        // a + b
  word_t difference; // a - b
  logic  lessThan;   // Signed a < b

  // ----------------------------------------
  // Shared arithmetic
  // ----------------------------------------
  assign sum        = a + b;
  assign difference = a - b;

  // Signed compare from the subtraction and the operand signs
  always_comb begin
    if (a[WordBits-1] != b[WordBits-1]) begin
      lessThan = a[WordBits-1]; // Negative a is the smaller one
    end else begin
      lessThan = difference[WordBits-1];
    end
  end

  // ----------------------------------------
  // Result select
  // ----------------------------------------
  always_comb begin
    case (aluOp)
      AluAdd:  result = sum;
      AluSub:  result = difference;
      AluSlt:  result = {{(WordBits-1){1'b0}}, lessThan};
      AluXor:  result = a ^ b;
      AluNone: result = '0;
      default: result = '0; // Unused codes
    endcase
  end

  // beq tests this after AluSub
  assign zero = (result == '0);

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/10ps
// Register file with two asynchronous reads and one clocked write
// r0 always reads zero
module registerFile (
  input  logic                begintest,
  input  logic                rst,
  input  cpuCfgPkg::regAddr_t readAddrA,
  input  cpuCfgPkg::regAddr_t readAddrB,
  output cpuCfgPkg::word_t    readDataA,
  output cpuCfgPkg::word_t    readDataB,
  input  logic                writeEn,
  input  cpuCfgPkg::regAddr_t writeAddr,
  input  cpuCfgPkg::word_t    writeData
);
  import cpuCfgPkg::*;

  word_t regs [RegCount];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (!rst && writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeData; // r0 writes dropped
    end
  end

  // Read ports force r0 to zero
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== hw/instMemory.sv ====
`timescale 1ns/10ps
// Program memory with combinational fetch
// Filled word by word through the load port while in reset
module instMemory #(
  parameter int IMemWords = 256
) (
  input  logic             begintest,
  input  logic             rst,
  input  cpuCfgPkg::word_t fetchAddr,   // Byte address from pc
  output cpuCfgPkg::word_t instruction,
  input  logic             loadEn,
  input  cpuCfgPkg::word_t loadAddr,    // Word index
  input  cpuCfgPkg::word_t loadData
);
  import cpuCfgPkg::*;

  localparam int IdxBits = $clog2(IMemWords);

  word_t mem [IMemWords];

  // ----------------------------------------
  // Load port
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (rst && loadEn) begin
      mem[loadAddr[IdxBits-1:0]] <= loadData;
    end
  end

  // Fetch, byte offset dropped
  assign instruction = mem[fetchAddr[IdxBits+1:2]];

  // Program is only written before the core starts running
  loadOnlyInReset: assert property (@(posedge begintest) loadEn |-> rst)
    else $error("Program load outside reset");

endmodule

// ==== hw/dataMemory.sv ====
`timescale 1ns/10ps
// Data memory, word array addressed by byte address
// Asynchronous read, write on the rising edge outside reset
module dataMemory #(
  parameter int DMemWords = 256
) (
  input  logic             begintest,
  input  logic             rst,
  input  cpuCfgPkg::word_t addr,      // ALU result
  input  cpuCfgPkg::word_t writeData,
  input  logic             memRead,
  input  logic             memWrite,
  output cpuCfgPkg::word_t readData
);
  import cpuCfgPkg::*;

  localparam int IdxBits = $clog2(DMemWords);

  word_t mem [DMemWords];
  logic [IdxBits-1:0] wordIdx;

  assign wordIdx = addr[IdxBits+1:2]; // Low two bits ignored

  // ----------------------------------------
  // Write and read
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (!rst && memWrite) begin
      mem[wordIdx] <= writeData;
    end
  end

  assign readData = memRead ? mem[wordIdx] : '0; // Quiet unless lw

  // Decoder never asks for a load and a store at once
  noReadWrite: assert property (
    @(posedge begintest) disable iff (rst) !(memRead && memWrite)
  ) else $error("memRead and memWrite both high");

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/10ps
// Single-cycle core top level
// PC, next-PC select, sign extension and the datapath muxes
module cpu #(
  parameter int IMemWords = cpuCfgPkg::DefaultIMemWords,
  parameter int DMemWords = cpuCfgPkg::DefaultDMemWords
) (
  input  logic             begintest,
  input  logic             rst,
  input  logic             loadEn,
  input  cpuCfgPkg::word_t loadAddr,
  input  cpuCfgPkg::word_t loadData,
  output cpuCfgPkg::word_t pc,        // Instruction executing now
  output logic             storeEn,
  output cpuCfgPkg::word_t storeAddr, // Byte address
  output cpuCfgPkg::word_t storeData
);
  import cpuIsaPkg::*;
  import cpuCfgPkg::*;

  word_t     instruction;
  regDst_t   regDst;
  logic      branch;
  logic      memRead;
  memtoReg_t memtoReg;
  aluOp_t    aluOp;
  logic      memWrite;
  logic      aluSrc;
  logic      regWrite;
  jump_t     jump;

  word_t    readDataA, readDataB;
  word_t    immExt;       // Sign-extended imm16
  word_t    aluB;
  word_t    aluResult;
  logic     aluZero;
  word_t    memReadData;
  regAddr_t writeAddr;
  word_t    writeData;
  word_t    pcPlus4, branchTarget, jumpTarget, pcNext;

  // ----------------------------------------
  // Program counter
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (rst) pc <= '0;
    else     pc <= pcNext;
  end

  assign pcPlus4      = pc + 32'd4;
  assign immExt       = {{(WordBits-ImmHi-1){instruction[ImmHi]}}, instruction[ImmHi:ImmLo]};
  assign branchTarget = pcPlus4 + {immExt[WordBits-3:0], 2'b00};
  assign jumpTarget   = {pcPlus4[WordBits-1:WordBits-4], instruction[TargetHi:TargetLo], 2'b00};

  always_comb begin
    case (jump)
      JumpAbs: pcNext = jumpTarget;
      JumpReg: pcNext = readDataA; // jr through rs
      default: pcNext = (branch && aluZero) ? branchTarget : pcPlus4;
    endcase
  end

  // ----------------------------------------
  // Datapath muxes
  // ----------------------------------------
  assign aluB = aluSrc ? immExt : readDataB;

  always_comb begin
    case (regDst)
      DstRt:   writeAddr = instruction[RtHi:RtLo];
      DstRa:   writeAddr = LinkReg;
      default: writeAddr = instruction[RdHi:RdLo];
    endcase
  end

  always_comb begin
    case (memtoReg)
      FromMem:  writeData = memReadData;
      FromLink: writeData = pcPlus4; // Return address
      default:  writeData = aluResult;
    endcase
  end

  // Store bus mirrors the data memory write
  assign storeEn   = memWrite && !rst;
  assign storeAddr = aluResult;
  assign storeData = readDataB;

  // ----------------------------------------
  // Blocks
  // ----------------------------------------
  instMemory #(.IMemWords(IMemWords)) iMem (
    .begintest(begintest), .rst(rst), .fetchAddr(pc), .instruction(instruction),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData)
  );

  control decoder (
    .instruction(instruction[OpHi:OpLo]), .regDst(regDst), .branch(branch),
    .memRead(memRead), .memtoReg(memtoReg), .aluOp(aluOp), .memWrite(memWrite),
    .aluSrc(aluSrc), .regWrite(regWrite), .jump(jump)
  );

  registerFile regs (
    .begintest(begintest), .rst(rst),
    .readAddrA(instruction[RsHi:RsLo]), .readAddrB(instruction[RtHi:RtLo]),
    .readDataA(readDataA), .readDataB(readDataB),
    .writeEn(regWrite), .writeAddr(writeAddr), .writeData(writeData)
  );

  alu mainAlu (
    .aluOp(aluOp), .a(readDataA), .b(aluB), .result(aluResult), .zero(aluZero)
  );

  dataMemory #(.DMemWords(DMemWords)) dMem (
    .begintest(begintest), .rst(rst), .addr(aluResult), .writeData(readDataB),
    .memRead(memRead), .memWrite(memWrite), .readData(memReadData)
  );

endmodule

// ==== tests/cpuRefModel.svh ====
// Instruction-set reference model and program builder for the core testbench
// Included inside the testbench module body
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// ----------------------------------------
// Opcodes, bits 31 to 26
// ----------------------------------------
localparam logic [5:0] RefAdd  = 6'b100000;
localparam logic [5:0] RefSub  = 6'b100010;
localparam logic [5:0] RefSlt  = 6'b101010;
localparam logic [5:0] RefXori = 6'b001110;
localparam logic [5:0] RefAddi = 6'b001000;
localparam logic [5:0] RefLw   = 6'b100011;
localparam logic [5:0] RefSw   = 6'b101011;
localparam logic [5:0] RefBeq  = 6'b000100;
localparam logic [5:0] RefJ    = 6'b000010;
localparam logic [5:0] RefJal  = 6'b000011;
localparam logic [5:0] RefJr   = 6'b001001;
localparam logic [5:0] RefBad  = 6'b111111; // Not in the instruction set

logic [31:0] progWords [$];  // Program image, one word per entry
logic [31:0] refRegs [32];
logic [31:0] refMem [256];   // Same depth as the DUT data memory
logic [31:0] refPc;
logic [31:0] haltPc;         // Final self loop

function automatic logic [31:0] encodeReg(logic [5:0] op, logic [4:0] rs, rt, rd);
  return {op, rs, rt, rd, 11'd0};
endfunction

function automatic logic [31:0] encodeImm(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encodeJump(logic [5:0] op, logic [25:0] target);
  return {op, target};
endfunction

function automatic void writeRefReg(logic [4:0] idx, logic [31:0] val);
  if (idx != 5'd0) refRegs[idx] = val; // r0 stays zero
endfunction

// ----------------------------------------
// One instruction, returns the store bus
// ----------------------------------------
function automatic void runModelStep(output logic stEn, output logic [31:0] stAddr,
                                     output logic [31:0] stData);
  logic [31:0] inst;
  logic [31:0] rsVal;
  logic [31:0] rtVal;
  logic [31:0] imm;
  logic [31:0] pcPlus4;
  logic [31:0] nextPc;
  inst    = progWords[refPc[31:2]];
  rsVal   = refRegs[inst[25:21]];
  rtVal   = refRegs[inst[20:16]];
  imm     = {{16{inst[15]}}, inst[15:0]}; // Sign extended for every I-type
  pcPlus4 = refPc + 32'd4;
  nextPc  = pcPlus4;
  stEn    = 1'b0;
  stAddr  = rsVal + imm;
  stData  = rtVal;
  case (inst[31:26])
    RefAdd:  writeRefReg(inst[15:11], rsVal + rtVal);
    RefSub:  writeRefReg(inst[15:11], rsVal - rtVal);
    RefSlt:  writeRefReg(inst[15:11], {31'd0, $signed(rsVal) < $signed(rtVal)});
    RefXori: writeRefReg(inst[20:16], rsVal ^ imm);
    RefAddi: writeRefReg(inst[20:16], rsVal + imm);
    RefLw:   writeRefReg(inst[20:16], refMem[stAddr[9:2]]);
    RefSw: begin
      stEn = 1'b1;
      refMem[stAddr[9:2]] = rtVal;
    end
    RefBeq:  if (rsVal == rtVal) nextPc = pcPlus4 + (imm << 2);
    RefJ:    nextPc = {pcPlus4[31:28], inst[25:0], 2'b00};
    RefJal: begin
      writeRefReg(5'd31, pcPlus4); // Link
      nextPc = {pcPlus4[31:28], inst[25:0], 2'b00};
    end
    RefJr:   nextPc = rsVal;
    default: ; // Unknown opcode, plain pc+4
  endcase
  refPc = nextPc;
endfunction

`endif

// ==== tests/cpuTb.sv ====
`timescale 1ns/10ps
// Testbench for the single-cycle core
// Loads a random program in reset, checks pc and the store bus every cycle
module cpuTb;

  localparam int ResetCycles = 10;
  localparam int Margin      = 20;

  logic        begintest;
  logic        rst;
  logic        loadEn;
  logic [31:0] loadAddr;
  logic [31:0] loadData;
  logic [31:0] pc;
  logic        storeEn;
  logic [31:0] storeAddr;
  logic [31:0] storeData;

  logic [31:0] lcgState;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleLimit = 0;
  logic        progReady  = 1'b0;
  logic        runDone    = 1'b0; // Model reached the final loop

  cpu dut (
    .begintest(begintest), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr),
    .loadData(loadData), .pc(pc), .storeEn(storeEn), .storeAddr(storeAddr),
    .storeData(storeData)
  );

  // LCG, upper bits returned
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return {8'd0, lcgState[31:8]};
  endfunction

  function automatic logic [4:0] randReg(int base, int span);
    logic [31:0] r;
    r = base + nextRand() % span;
    return r[4:0];
  endfunction

  function automatic logic [15:0] randOffset();
    logic [31:0] r;
    r = (nextRand() % 200) * 4; // Word aligned, inside data memory
    return r[15:0];
  endfunction

  `include "cpuRefModel.svh"

  // ----------------------------------------
  // Random program, every register written before it is read
  // ----------------------------------------
  function automatic void buildProgram();
    logic [4:0]  rA, rB, rC, rD, rE;
    logic [15:0] immA, immB, off;
    int          jalIdx;
    rA   = randReg(1, 6);
    rB   = randReg(8, 6);
    rC   = randReg(15, 6);
    rD   = randReg(22, 4);
    rE   = randReg(27, 3);
    immA = nextRand();
    immB = nextRand();
    if (immB == immA) immB = ~immA; // beq must fall through later
    progWords.delete();
    progWords.push_back(encodeImm(RefAddi, 5'd0, rA, immA));
    progWords.push_back(encodeImm(RefAddi, 5'd0, rB, immB));
    progWords.push_back(encodeImm(RefXori, rA, rC, nextRand()));
    progWords.push_back(encodeImm(RefSw, 5'd0, rC, randOffset()));
    progWords.push_back(encodeReg(RefAdd, rA, rB, rD));
    progWords.push_back(encodeImm(RefSw, 5'd0, rD, randOffset()));
    progWords.push_back(encodeReg(RefSub, rA, rB, rD));
    progWords.push_back(encodeImm(RefSw, 5'd0, rD, randOffset()));
    progWords.push_back(encodeReg(RefSlt, rA, rB, rD));
    progWords.push_back(encodeImm(RefSw, 5'd0, rD, randOffset()));
    progWords.push_back(encodeReg(RefSlt, rB, rA, rD)); // Operands swapped
    progWords.push_back(encodeImm(RefSw, 5'd0, rD, randOffset()));
    // Store, load back, store elsewhere
    off = randOffset();
    progWords.push_back(encodeImm(RefSw, 5'd0, rA, off));
    progWords.push_back(encodeImm(RefLw, 5'd0, rE, off));
    progWords.push_back(encodeImm(RefSw, 5'd0, rE, randOffset()));
    // Branch taken then not taken
    progWords.push_back(encodeImm(RefBeq, rA, rA, 16'd1));
    progWords.push_back(encodeImm(RefSw, 5'd0, rC, randOffset())); // Skipped
    progWords.push_back(encodeImm(RefBeq, rA, rB, 16'd1));
    progWords.push_back(encodeImm(RefSw, 5'd0, rB, randOffset()));
    // Jumps, subroutine placed after the halt loop
    progWords.push_back(encodeJump(RefJ, progWords.size() + 2));
    progWords.push_back(encodeImm(RefSw, 5'd0, rA, randOffset())); // Skipped
    jalIdx = progWords.size();
    progWords.push_back('0);                             // jal patched below
    progWords.push_back(encodeReg(RefBad, rA, rB, rA));  // Would clobber rA
    progWords.push_back(encodeImm(RefSw, 5'd0, rA, randOffset()));
    haltPc = progWords.size() * 4;
    progWords.push_back(encodeJump(RefJ, progWords.size()));
    progWords[jalIdx] = encodeJump(RefJal, progWords.size());
    progWords.push_back(encodeImm(RefSw, 5'd0, 5'd31, randOffset()));
    progWords.push_back(encodeReg(RefJr, 5'd31, 5'd0, 5'd0));
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("ERROR %s: got %h, expected %h at %0t", name, got, expected, $time);
    end
  endtask

  initial begin
    begintest = 1'b0;
    forever #20 begintest = ~begintest; // 40 ns period
  end

  // ----------------------------------------
  // Load, reset release, final report
  // ----------------------------------------
  initial begin
    rst      = 1'b1;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    lcgState = 32'h69cf;
    foreach (refRegs[i]) refRegs[i] = '0;
    refPc = '0;
    buildProgram();
    cycleLimit = 2 * progWords.size() + ResetCycles + Margin; // Load, reset, run
    progReady  = 1'b1;
    foreach (progWords[i]) begin
      @(negedge begintest);
      loadEn   = 1'b1;
      loadAddr = i;
      loadData = progWords[i];
    end
    @(negedge begintest);
    loadEn = 1'b0;
    repeat (ResetCycles - 1) @(negedge begintest);
    rst = 1'b0;
    wait (runDone);
    @(negedge begintest);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Compare at each rising edge, values of the cycle just ending
  initial begin : compareProcess
    logic        expStoreEn;
    logic [31:0] expStoreAddr;
    logic [31:0] expStoreData;
    logic [31:0] expPc;
    bit          pcValid;
    pcValid = 1'b0;
    while (!runDone) begin
      @(posedge begintest);
      if (rst) begin
        if (pcValid) checkValue("pc", pc, 32'd0); // pc unknown before first edge
        checkValue("storeEn", storeEn, 32'd0);
        pcValid = 1'b1;
      end else begin
        expPc = refPc;
        runModelStep(expStoreEn, expStoreAddr, expStoreData);
        checkValue("pc", pc, expPc);
        checkValue("storeEn", storeEn, expStoreEn);
        if (expStoreEn) begin
          checkValue("storeAddr", storeAddr, expStoreAddr);
          checkValue("storeData", storeData, expStoreData);
        end
        if (expPc == haltPc) runDone = 1'b1;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (progReady);
    while (cycles < cycleLimit) begin
      @(posedge begintest);
      cycles++;
    end
    $display("Timeout after %0d cycles, program never reached its final loop (%0d errors)",
             cycleLimit, errorCount);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
hw/cpuIsaPkg.sv
hw/cpuCfgPkg.sv
hw/control.sv
hw/alu.sv
hw/registerFile.sv
hw/instMemory.sv
hw/dataMemory.sv
hw/cpu.sv
tests/cpuTb.sv
